//--- list.f
code_defs_pkg.sv
rx_crc32.sv
rx_mac.sv
rx_mac_top.sv
rx_mac_sva.sv
tb_rx_mac.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_rx_mac
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= No errors

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILE_LIST)) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_rx_mac.sv
`timescale 1ns/100ps

module tb_rx_mac import code_defs_pkg::*; ();

    localparam int NUM_TESTS = 11;
    localparam int KIND_FRAME = 0;
    localparam int KIND_IDLE = 1;
    localparam int KIND_BAD_SFD = 2;

    logic                   rx_clk;
    logic                   rx_reset;
    logic [DATA_WIDTH-1:0]  xgmii_rx_data;
    logic [DATA_NBYTES-1:0] xgmii_rx_ctl;
    logic                   phy_rx_valid;
    logic [DATA_NBYTES-1:0] term_loc;
    logic [DATA_WIDTH-1:0]  m00_axis_tdata;
    logic [DATA_NBYTES-1:0] m00_axis_tkeep;
    logic                   m00_axis_tvalid;
    logic                   m00_axis_tlast;
    logic                   m00_axis_tuser;

    // Payload lengths exclude the 14 header bytes and the FCS
    // Gap mode 1 replays the previous frame with phy_rx_valid gaps
    int t_kind[NUM_TESTS]    = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 2};
    int t_len[NUM_TESTS]     = '{46, 47, 48, 49, 46, 42, 50, 53, 53, 0, 48};
    int t_corrupt[NUM_TESTS] = '{-1, -1, -1, -1, 20, -1, -1, -1, -1, -1, -1};
    int t_errc[NUM_TESTS]    = '{-1, -1, -1, -1, -1, -1, 30, -1, -1, -1, -1};
    int t_gap[NUM_TESTS]     = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0};
    logic t_bad[NUM_TESTS]   = '{0, 0, 0, 0, 1, 1, 1, 0, 0, 0, 0};

    int seed = 32'h939ae179;
    int errors = 0;
    int test_errors;
    int last_cnt;
    int beat_cnt;
    logic last_user;
    logic [3:0] last_keep;
    logic [7:0] frame_q[$];
    logic ctlb_q[$];
    logic [7:0] out_q[$];
    logic [7:0] prev_q[$];
    logic [31:0] wd_q[$];
    logic [3:0] wc_q[$];
    logic [3:0] wt_q[$];

    rx_mac_top dut (
        .rx_clk          (rx_clk),
        .rx_reset        (rx_reset),
        .xgmii_rx_data   (xgmii_rx_data),
        .xgmii_rx_ctl    (xgmii_rx_ctl),
        .phy_rx_valid    (phy_rx_valid),
        .term_loc        (term_loc),
        .m00_axis_tdata  (m00_axis_tdata),
        .m00_axis_tkeep  (m00_axis_tkeep),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tlast  (m00_axis_tlast),
        .m00_axis_tuser  (m00_axis_tuser)
    );

    initial begin
        rx_clk = 1'b0;
        forever #2 rx_clk = ~rx_clk;
    end

    // Bit-serial Ethernet FCS with the LSB of each byte first
    function automatic logic [31:0] fcs_of(input logic [7:0] bytes[$]);
        logic [31:0] r;
        r = 32'hFFFFFFFF;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                if (r[0] ^ bytes[i][b]) begin
                    r = (r >> 1) ^ CRC32_POLY;
                end else begin
                    r = r >> 1;
                end
            end
        end
        return ~r;
    endfunction

    task automatic note_error(input string msg);
        $display("%s", msg);
        test_errors++;
    endtask

    task automatic check_zero(input string name, input logic [31:0] value);
        if (value != '0) begin
            note_error($sformatf("MISMATCH %s during reset: expected %h, got %h",
                                 name, 32'h0, value));
        end
    endtask

    task automatic queue_word(input logic [31:0] d, input logic [3:0] c, input logic [3:0] t);
        wd_q.push_back(d);
        wc_q.push_back(c);
        wt_q.push_back(t);
    endtask

    task automatic build_frame(input int idx);
        logic [31:0] fcs;
        logic [31:0] w;
        logic [3:0] c;
        int n;
        int k;
        if (t_gap[idx] == 0) begin
            frame_q.delete();
            for (int i = 0; i < t_len[idx] + 14; i++) begin
                frame_q.push_back(8'($random(seed)));
            end
            // Error byte goes into the FCS so only its control flag makes the frame bad
            if (t_errc[idx] >= 0) begin
                frame_q[t_errc[idx]] = XGMII_ERROR;
            end
            fcs = fcs_of(frame_q);
            for (int i = 0; i < FCS_BYTES; i++) begin
                frame_q.push_back(fcs[8*i +: 8]);
            end
        end
        n = frame_q.size();
        ctlb_q.delete();
        for (int i = 0; i < n; i++) begin
            ctlb_q.push_back(1'b0);
        end
        if (t_corrupt[idx] >= 0) begin
            frame_q[t_corrupt[idx]] = frame_q[t_corrupt[idx]] ^ 8'hFF;
        end
        if (t_errc[idx] >= 0) begin
            ctlb_q[t_errc[idx]] = 1'b1;
        end
        queue_word({{3{PREAMBLE_BYTE}}, XGMII_START}, 4'b0001, 4'b0000);
        if (t_kind[idx] == KIND_BAD_SFD) begin
            queue_word({8'hD4, {3{PREAMBLE_BYTE}}}, 4'b0000, 4'b0000);
        end else begin
            queue_word({SFD_BYTE, {3{PREAMBLE_BYTE}}}, 4'b0000, 4'b0000);
        end
        for (int i = 0; i + 4 <= n; i += 4) begin
            for (int l = 0; l < 4; l++) begin
                w[8*l +: 8] = frame_q[i+l];
                c[l] = ctlb_q[i+l];
            end
            queue_word(w, c, 4'b0000);
        end
        // Leftover bytes, then the terminate and idle fill
        k = n % 4;
        for (int l = 0; l < 4; l++) begin
            if (l < k) begin
                w[8*l +: 8] = frame_q[n-k+l];
                c[l] = 1'b0;
            end else begin
                w[8*l +: 8] = (l == k) ? XGMII_TERM : XGMII_IDLE;
                c[l] = 1'b1;
            end
        end
        queue_word(w, c, 4'(1 << k));
        repeat (4) queue_word({4{XGMII_IDLE}}, 4'hF, 4'b0000);
    endtask

    task automatic drive_idle(input logic valid);
        xgmii_rx_data = {4{XGMII_IDLE}};
        xgmii_rx_ctl = 4'hF;
        term_loc = 4'b0000;
        phy_rx_valid = valid;
    endtask

    task automatic drive_words(input bit gaps);
        foreach (wd_q[i]) begin
            while (gaps && ($random(seed) & 3) == 0) begin
                @(posedge rx_clk);
                #1;
                drive_idle(1'b0);
            end
            @(posedge rx_clk);
            #1;
            xgmii_rx_data = wd_q[i];
            xgmii_rx_ctl = wc_q[i];
            term_loc = wt_q[i];
            phy_rx_valid = 1'b1;
        end
        @(posedge rx_clk);
        #1;
        drive_idle(1'b1);
    endtask

    // Beats are collected on the falling edge
    always @(negedge rx_clk) begin
        if (!rx_reset && m00_axis_tvalid) begin
            beat_cnt++;
            for (int l = 0; l < 4; l++) begin
                if (m00_axis_tkeep[l]) begin
                    out_q.push_back(m00_axis_tdata[8*l +: 8]);
                end
            end
            if (m00_axis_tlast) begin
                last_cnt++;
                last_user = m00_axis_tuser;
                last_keep = m00_axis_tkeep;
            end
        end
    end

    task automatic check_frame(input int idx);
        int exp_len;
        int rem;
        logic [3:0] exp_keep;
        exp_len = frame_q.size() - FCS_BYTES;
        if (out_q.size() != exp_len) begin
            note_error($sformatf("MISMATCH byte count: expected %h, got %h",
                                 exp_len, out_q.size()));
        end else begin
            foreach (out_q[i]) begin
                if (out_q[i] != frame_q[i]) begin
                    note_error($sformatf("MISMATCH m00_axis_tdata byte %0d: expected %h, got %h",
                                         i, frame_q[i], out_q[i]));
                end
            end
        end
        rem = exp_len % 4;
        exp_keep = (rem == 0) ? 4'hF : 4'((1 << rem) - 1);
        if (last_keep != exp_keep) begin
            note_error($sformatf("MISMATCH m00_axis_tkeep: expected %h, got %h",
                                 exp_keep, last_keep));
        end
        if (last_user != t_bad[idx]) begin
            note_error($sformatf("MISMATCH m00_axis_tuser: expected %h, got %h",
                                 t_bad[idx], last_user));
        end
        if (t_gap[idx] != 0) begin
            if (out_q.size() != prev_q.size()) begin
                note_error($sformatf("MISMATCH byte count of gap-free run: expected %h, got %h",
                                     prev_q.size(), out_q.size()));
            end else begin
                foreach (out_q[i]) begin
                    if (out_q[i] != prev_q[i]) begin
                        note_error($sformatf(
                            "MISMATCH m00_axis_tdata byte %0d of gap-free run: expected %h, got %h",
                            i, prev_q[i], out_q[i]));
                    end
                end
            end
        end
    endtask

    task automatic run_test(input int idx);
        int wait_cyc;
        test_errors = 0;
        out_q.delete();
        last_cnt = 0;
        beat_cnt = 0;
        wd_q.delete();
        wc_q.delete();
        wt_q.delete();
        if (t_kind[idx] == KIND_IDLE) begin
            repeat (12) queue_word({4{XGMII_IDLE}}, 4'hF, 4'b0000);
        end else begin
            build_frame(idx);
        end
        drive_words(t_gap[idx] != 0);
        if (t_kind[idx] != KIND_FRAME) begin
            repeat (16) @(posedge rx_clk);
            if (beat_cnt != 0) begin
                note_error("output beats appeared where nothing should be received");
            end
        end else begin
            wait_cyc = 0;
            while (last_cnt == 0 && wait_cyc < 64) begin
                @(posedge rx_clk);
                wait_cyc++;
            end
            if (last_cnt == 0) begin
                note_error("timed out waiting for tlast");
            end else begin
                repeat (8) @(posedge rx_clk);
                if (last_cnt != 1) begin
                    note_error("more than one tlast seen for a single frame");
                end
                check_frame(idx);
            end
            prev_q = out_q;
        end
        errors += test_errors;
        $display("test %0d: %s", idx, (test_errors == 0) ? "pass" : "FAIL");
    endtask

    initial begin
        int limit;
        limit = 300;
        foreach (t_len[i]) begin
            limit += ((t_len[i] + 40) / 4) * 4 + 100;
        end
        #(limit * 4);
        $display("watchdog expired after %0d cycles", limit);
        $display("Errors found");
        $finish;
    end

    initial begin
        rx_reset = 1'b1;
        drive_idle(1'b0);
        test_errors = 0;
        repeat (8) begin
            @(posedge rx_clk);
            #1;
            check_zero("m00_axis_tdata", m00_axis_tdata);
            check_zero("m00_axis_tkeep", m00_axis_tkeep);
            check_zero("m00_axis_tvalid", m00_axis_tvalid);
            check_zero("m00_axis_tlast", m00_axis_tlast);
            check_zero("m00_axis_tuser", m00_axis_tuser);
        end
        rx_reset = 1'b0;
        errors += test_errors;
        repeat (4) @(posedge rx_clk);
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        errors += dut.u_sva.fail_count;
        $display("tests %0d, errors %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- rx_mac_sva.sv
`timescale 1ns/100ps

module rx_mac_sva import code_defs_pkg::*; (
    input logic                   rx_clk,
    input logic                   rx_reset,
    input logic [DATA_NBYTES-1:0] m00_axis_tkeep,
    input logic                   m00_axis_tvalid,
    input logic                   m00_axis_tlast,
    input logic                   m00_axis_tuser
);

    int fail_count = 0;

    // Output register clears while reset is held
    assert property (@(posedge rx_clk) rx_reset |=> !m00_axis_tvalid)
        else begin
            $error("tvalid high during reset");
            fail_count++;
        end

    assert property (@(posedge rx_clk) disable iff (rx_reset)
        m00_axis_tvalid |-> m00_axis_tkeep != '0)
        else begin
            $error("tvalid with empty tkeep");
            fail_count++;
        end

    // Partial beats only at the end of a frame
    assert property (@(posedge rx_clk) disable iff (rx_reset)
        m00_axis_tvalid && !m00_axis_tlast |-> &m00_axis_tkeep)
        else begin
            $error("partial tkeep on a beat without tlast");
            fail_count++;
        end

    assert property (@(posedge rx_clk) disable iff (rx_reset)
        !m00_axis_tlast |-> !m00_axis_tuser)
        else begin
            $error("tuser high without tlast");
            fail_count++;
        end

endmodule

bind rx_mac_top rx_mac_sva u_sva (
    .rx_clk          (rx_clk),
    .rx_reset        (rx_reset),
    .m00_axis_tkeep  (m00_axis_tkeep),
    .m00_axis_tvalid (m00_axis_tvalid),
    .m00_axis_tlast  (m00_axis_tlast),
    .m00_axis_tuser  (m00_axis_tuser)
);

//--- rx_mac_top.sv
`timescale 1ns/100ps

module rx_mac_top import code_defs_pkg::*; (
    input  logic                   rx_clk,
    input  logic                   rx_reset,
    input  logic [DATA_WIDTH-1:0]  xgmii_rx_data,
    input  logic [DATA_NBYTES-1:0] xgmii_rx_ctl,
    input  logic                   phy_rx_valid,
    input  logic [DATA_NBYTES-1:0] term_loc,
    output logic [DATA_WIDTH-1:0]  m00_axis_tdata,
    output logic [DATA_NBYTES-1:0] m00_axis_tkeep,
    output logic                   m00_axis_tvalid,
    output logic                   m00_axis_tlast,
    output logic                   m00_axis_tuser
);

    logic [DATA_WIDTH-1:0]  rx_tdata;
    logic [DATA_NBYTES-1:0] rx_tkeep;
    logic                   rx_tvalid;
    logic                   rx_tlast;
    logic                   rx_tuser;

    rx_mac u_rx (
        .rx_clk       (rx_clk),
        .rx_reset     (rx_reset),
        .xgmii_rxd    (xgmii_rx_data),
        .xgmii_rxc    (xgmii_rx_ctl),
        .phy_rx_valid (phy_rx_valid),
        .term_loc     (term_loc),
        .rx_tdata     (rx_tdata),
        .rx_tkeep     (rx_tkeep),
        .rx_tvalid    (rx_tvalid),
        .rx_tlast     (rx_tlast),
        .rx_tuser     (rx_tuser)
    );

    // Output stage toward user logic
    always_ff @(posedge rx_clk) begin
        if (rx_reset) begin
            m00_axis_tdata <= '0;
            m00_axis_tkeep <= '0;
            m00_axis_tvalid <= 1'b0;
            m00_axis_tlast <= 1'b0;
            m00_axis_tuser <= 1'b0;
        end else begin
            m00_axis_tdata <= rx_tdata;
            m00_axis_tkeep <= rx_tkeep;
            m00_axis_tvalid <= rx_tvalid;
            m00_axis_tlast <= rx_tlast;
            m00_axis_tuser <= rx_tuser;
        end
    end

endmodule

//--- rx_mac.sv
`timescale 1ns/100ps

module rx_mac import code_defs_pkg::*; (
    input  logic                   rx_clk,
    input  logic                   rx_reset,
    input  logic [DATA_WIDTH-1:0]  xgmii_rxd,
    input  logic [DATA_NBYTES-1:0] xgmii_rxc,
    input  logic                   phy_rx_valid,
    input  logic [DATA_NBYTES-1:0] term_loc,
    output logic [DATA_WIDTH-1:0]  rx_tdata,
    output logic [DATA_NBYTES-1:0] rx_tkeep,
    output logic                   rx_tvalid,
    output logic                   rx_tlast,
    output logic                   rx_tuser
);

    logic [1:0]             state_q;
    logic [15:0]            len_q;
    logic                   err_q;
    logic [DATA_WIDTH-1:0]  buf0_q;
    logic [DATA_WIDTH-1:0]  buf1_q;
    logic [1:0]             buf_cnt_q;
    logic                   fin_q;
    logic [DATA_WIDTH-1:0]  fin_data_q;
    logic [DATA_NBYTES-1:0] fin_keep_q;
    logic                   fin_err_q;
    logic                   fin_short_q;

    logic                   is_start;
    logic                   pre_ok;
    logic                   sfd_ok;
    logic                   term_hit;
    logic [DATA_NBYTES-1:0] term_mask;
    logic                   in_data;
    logic                   restart;
    logic                   close_term;
    logic                   plain;
    logic [DATA_NBYTES-1:0] lane_mask;
    logic                   has_tail;
    logic                   word_err;
    logic [15:0]            len_next;
    logic                   fin_set;
    logic                   emit_buf0;
    logic                   crc_clear;
    logic                   crc_ok;

    assign is_start = xgmii_rxc[0] && xgmii_rxd[7:0] == XGMII_START;
    assign pre_ok = xgmii_rxc == 4'b0001 && xgmii_rxd[31:8] == {3{PREAMBLE_BYTE}};
    assign sfd_ok = xgmii_rxc == '0 &&
                    xgmii_rxd == {SFD_BYTE, PREAMBLE_BYTE, PREAMBLE_BYTE, PREAMBLE_BYTE};

    // Terminate needs both the PHY lane marker and the control code
    always_comb begin
        term_hit = 1'b0;
        for (int i = 0; i < DATA_NBYTES; i++) begin
            if (term_loc[i] && xgmii_rxc[i] && xgmii_rxd[8*i +: 8] == XGMII_TERM) begin
                term_hit = 1'b1;
            end
        end
    end

    // Lanes below the terminate hold frame bytes
    assign term_mask = term_loc - 1'b1;

    assign in_data = phy_rx_valid && state_q == RX_DATA;
    assign restart = in_data && is_start;
    assign close_term = in_data && !is_start && term_hit;
    assign plain = in_data && !is_start && !term_hit;

    assign lane_mask = restart ? '0 : term_mask;
    assign has_tail = |lane_mask;
    assign word_err = restart || (plain ? |xgmii_rxc : |(xgmii_rxc & term_mask));
    assign len_next = len_q + (plain ? 16'(DATA_NBYTES) : 16'($countones(lane_mask)));

    // Closing word: last four bytes before it are FCS and stay in the buffer
    assign fin_set = (restart || close_term) &&
                     (buf_cnt_q == 2'd2 || (buf_cnt_q == 2'd1 && has_tail));
    assign emit_buf0 = buf_cnt_q == 2'd2 && (plain || (close_term && has_tail));

    assign crc_clear = phy_rx_valid && is_start && (state_q == RX_IDLE || state_q == RX_DATA);

    rx_crc32 u_crc (
        .rx_clk   (rx_clk),
        .rx_reset (rx_reset),
        .clear    (crc_clear),
        .step     (plain || close_term),
        .data     (xgmii_rxd),
        .byte_en  (plain ? '1 : term_mask),
        .crc_ok   (crc_ok)
    );

    always_ff @(posedge rx_clk) begin
        if (rx_reset) begin
            state_q <= RX_IDLE;
            len_q <= '0;
            err_q <= 1'b0;
            buf_cnt_q <= '0;
            fin_q <= 1'b0;
        end else begin
            fin_q <= fin_set;
            if (phy_rx_valid) begin
                case (state_q)
                    RX_IDLE: begin
                        if (is_start) begin
                            state_q <= pre_ok ? RX_PREAMBLE : RX_DROP;
                            len_q <= '0;
                            err_q <= 1'b0;
                        end
                    end
                    RX_PREAMBLE: state_q <= sfd_ok ? RX_DATA : RX_DROP;
                    RX_DATA: begin
                        if (restart) begin
                            state_q <= pre_ok ? RX_PREAMBLE : RX_DROP;
                            len_q <= '0;
                            err_q <= 1'b0;
                            buf_cnt_q <= '0;
                        end else if (close_term) begin
                            state_q <= RX_IDLE;
                            buf_cnt_q <= '0;
                        end else begin
                            len_q <= len_next;
                            err_q <= err_q | word_err;
                            if (buf_cnt_q != 2'd2) begin
                                buf_cnt_q <= buf_cnt_q + 1'b1;
                            end
                        end
                    end
                    default: begin
                        // Dropped frame waits for its end or line idle
                        if (term_hit || &xgmii_rxc) begin
                            state_q <= RX_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (plain) begin
            buf0_q <= buf1_q;
            buf1_q <= xgmii_rxd;
        end
        if (fin_set) begin
            fin_data_q <= (buf_cnt_q == 2'd2 && !has_tail) ? buf0_q : buf1_q;
            fin_keep_q <= has_tail ? lane_mask : '1;
            fin_err_q <= err_q | word_err;
            fin_short_q <= len_next < MIN_FRAME_SIZE;
        end
    end

    // crc_ok already covers the closing word when the last beat goes out
    always_ff @(posedge rx_clk) begin
        if (rx_reset) begin
            rx_tdata <= '0;
            rx_tkeep <= '0;
            rx_tvalid <= 1'b0;
            rx_tlast <= 1'b0;
            rx_tuser <= 1'b0;
        end else begin
            rx_tvalid <= fin_q | emit_buf0;
            rx_tlast <= fin_q;
            rx_tuser <= fin_q & (fin_err_q | fin_short_q | !crc_ok);
            if (fin_q) begin
                rx_tdata <= fin_data_q;
                rx_tkeep <= fin_keep_q;
            end else if (emit_buf0) begin
                rx_tdata <= buf0_q;
                rx_tkeep <= '1;
            end
        end
    end

endmodule

//--- rx_crc32.sv
`timescale 1ns/100ps

module rx_crc32 import code_defs_pkg::*; (
    input  logic                   rx_clk,
    input  logic                   rx_reset,
    input  logic                   clear,
    input  logic                   step,
    input  logic [DATA_WIDTH-1:0]  data,
    input  logic [DATA_NBYTES-1:0] byte_en,
    output logic                   crc_ok
);

    // Held complemented, so the register reads as the FCS sent on the wire
    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // One byte, LSB first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'd0, b};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC32_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // Lane 0 is first on the wire
    always_comb begin
        crc_next = ~crc_q;
        for (int lane = 0; lane < DATA_NBYTES; lane++) begin
            if (byte_en[lane]) begin
                crc_next = crc_byte(crc_next, data[8*lane +: 8]);
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (rx_reset || clear) begin
            crc_q <= ~CRC32_INIT;
        end else if (step) begin
            crc_q <= ~crc_next;
        end
    end

    // Residue after the FCS itself has been folded in
    assign crc_ok = ~crc_q == CRC32_RESIDUE;

endmodule

//--- code_defs_pkg.sv
package code_defs_pkg;

    // XGMII word geometry
    localparam int DATA_WIDTH = 32;
    localparam int DATA_NBYTES = DATA_WIDTH / 8;

    // Control characters, valid with the lane control flag set
    localparam logic [7:0] XGMII_IDLE = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE = 8'hD5;

    localparam int MIN_PAYLOAD_SIZE = 46;
    localparam int FCS_BYTES = 4;
    // Payload plus 14 header bytes plus FCS
    localparam logic [15:0] MIN_FRAME_SIZE = 16'(MIN_PAYLOAD_SIZE + 14 + FCS_BYTES);

    // Reflected CRC-32 as used for the Ethernet FCS
    localparam logic [31:0] CRC32_POLY = 32'hEDB88320;
    localparam logic [31:0] CRC32_INIT = 32'hFFFFFFFF;
    localparam logic [31:0] CRC32_RESIDUE = 32'hDEBB20E3;

    // Receive parser states
    localparam logic [1:0] RX_IDLE = 2'd0;
    localparam logic [1:0] RX_PREAMBLE = 2'd1;
    localparam logic [1:0] RX_DATA = 2'd2;
    localparam logic [1:0] RX_DROP = 2'd3;

endpackage
